/* verilog/soc_pkg.sv */
// Shared bus types, timing constants and the fixed address map of the SoC glue logic
package soc_pkg;

  // Bus word and address types
  typedef logic [15:0] bus_data_t;
  typedef logic [18:0] bus_addr_t;
  typedef logic [1:0]  bus_sel_t;

  // Address with the I/O tag on top, as seen by the decoder
  typedef logic [19:0] tag_addr_t;

  // One-hot choice of the addressed slave
  typedef logic [5:0]  slave_sel_t;

  typedef logic [2:0]  iid_t;
  typedef logic [13:0] led_t;
  typedef logic [9:0]  sw_t;

  // Bit positions within slave_sel_t
  localparam int SEL_ROM  = 0;
  localparam int SEL_VGA  = 1;
  localparam int SEL_UART = 2;
  localparam int SEL_GPIO = 3;
  localparam int SEL_MEM  = 4;
  localparam int SEL_DEF  = 5;

  // Reset hold counter and timer clock divider
  localparam int RST_HOLD_BITS  = 10;
  localparam int TIMER_DIV_HIGH = 10;
  localparam int TIMER_DIV_LAST = 20;

  // Address windows as match/mask pairs, layout is {tga, adr[19:1]}
  // Boot ROM, memory 0xf0000 - 0xfffff
  localparam tag_addr_t ROM_MEM1_MATCH = 20'b0_1111_0000_0000_0000_000;
  localparam tag_addr_t ROM_MEM1_MASK  = 20'b1_1111_0000_0000_0000_000;
  // Boot ROM, memory 0xc0000 - 0xcffff
  localparam tag_addr_t ROM_MEM2_MATCH = 20'b0_1100_0000_0000_0000_000;
  localparam tag_addr_t ROM_MEM2_MASK  = 20'b1_1111_0000_0000_0000_000;
  // Boot ROM, I/O block at 0xe000 (0xe000 - 0xe1ff)
  localparam tag_addr_t ROM_IO_MATCH   = 20'b1_0000_1110_0000_0000_000;
  localparam tag_addr_t ROM_IO_MASK    = 20'b1_0000_1111_1110_0000_000;
  // Video, memory 0xa0000 - 0xbffff
  localparam tag_addr_t VGA_MEM_MATCH  = 20'b0_1010_0000_0000_0000_000;
  localparam tag_addr_t VGA_MEM_MASK   = 20'b1_1110_0000_0000_0000_000;
  // Video, I/O 0x3c0 - 0x3df
  localparam tag_addr_t VGA_IO_MATCH   = 20'b1_0000_0000_0011_1100_000;
  localparam tag_addr_t VGA_IO_MASK    = 20'b1_0000_1111_1111_1110_000;
  // Serial port, I/O 0x3f8 - 0x3ff
  localparam tag_addr_t UART_IO_MATCH  = 20'b1_0000_0000_0011_1111_100;
  localparam tag_addr_t UART_IO_MASK   = 20'b1_0000_1111_1111_1111_100;
  // Switches and LEDs, I/O 0xf100 - 0xf103
  localparam tag_addr_t GPIO_IO_MATCH  = 20'b1_0000_1111_0001_0000_000;
  localparam tag_addr_t GPIO_IO_MASK   = 20'b1_0000_1111_1111_1111_110;
  // Main memory takes every memory cycle left over
  localparam tag_addr_t MEM_ANY_MATCH  = 20'b0_0000_0000_0000_0000_000;
  localparam tag_addr_t MEM_ANY_MASK   = 20'b1_0000_0000_0000_0000_000;

  // Read data of unmapped I/O
  localparam bus_data_t DEFAULT_DATA = 16'hffff;

  // Interrupt vector base, id in the low three bits
  localparam bus_data_t INTA_BASE = 16'h0008;

endpackage

/* verilog/bus_switch.sv */
// Bus switch: decodes the tagged CPU address, routes strobes and returns data/ack to the CPU
`timescale 1ns/100ps

module bus_switch (
  // Master side
  input  soc_pkg::bus_addr_t m_adr_i,
  input  logic               m_tga_i,
  input  soc_pkg::bus_data_t m_dat_i,
  input  soc_pkg::bus_sel_t  m_sel_i,
  input  logic               m_we_i,
  input  logic               m_cyc_i,
  input  logic               m_stb_i,
  input  logic               inta_i,
  input  soc_pkg::iid_t      iid_i,
  output soc_pkg::bus_data_t m_dat_o,
  output logic               m_ack_o,

  // Shared slave signals
  output soc_pkg::bus_addr_t slv_adr_o,
  output logic               slv_tga_o,
  output soc_pkg::bus_data_t slv_dat_o,
  output soc_pkg::bus_sel_t  slv_sel_o,
  output logic               slv_we_o,

  // Per-slave requests and returns
  output logic               rom_cyc_o,
  output logic               rom_stb_o,
  input  soc_pkg::bus_data_t rom_dat_i,
  input  logic               rom_ack_i,
  output logic               vga_cyc_o,
  output logic               vga_stb_o,
  input  soc_pkg::bus_data_t vga_dat_i,
  input  logic               vga_ack_i,
  output logic               uart_cyc_o,
  output logic               uart_stb_o,
  input  soc_pkg::bus_data_t uart_dat_i,
  input  logic               uart_ack_i,
  output logic               mem_cyc_o,
  output logic               mem_stb_o,
  input  soc_pkg::bus_data_t mem_dat_i,
  input  logic               mem_ack_i,
  output logic               gpio_cyc_o,
  output logic               gpio_stb_o,
  input  soc_pkg::bus_data_t gpio_dat_i,
  input  logic               gpio_ack_i
);

  soc_pkg::tag_addr_t  tag_adr;
  soc_pkg::slave_sel_t slave_sel;
  soc_pkg::bus_data_t  ret_dat;
  logic                ret_ack;

  function automatic logic hit(
    soc_pkg::tag_addr_t adr,
    soc_pkg::tag_addr_t match,
    soc_pkg::tag_addr_t mask
  );
    return (adr & mask) == match;
  endfunction

  assign tag_adr = {m_tga_i, m_adr_i};

  // Priority decode, the first matching window wins
  always_comb
  begin
    slave_sel = '0;
    if (hit(tag_adr, soc_pkg::ROM_MEM1_MATCH, soc_pkg::ROM_MEM1_MASK) ||
        hit(tag_adr, soc_pkg::ROM_MEM2_MATCH, soc_pkg::ROM_MEM2_MASK) ||
        hit(tag_adr, soc_pkg::ROM_IO_MATCH, soc_pkg::ROM_IO_MASK))
      slave_sel[soc_pkg::SEL_ROM] = 1'b1;
    else if (hit(tag_adr, soc_pkg::VGA_MEM_MATCH, soc_pkg::VGA_MEM_MASK) ||
             hit(tag_adr, soc_pkg::VGA_IO_MATCH, soc_pkg::VGA_IO_MASK))
      slave_sel[soc_pkg::SEL_VGA] = 1'b1;
    else if (hit(tag_adr, soc_pkg::UART_IO_MATCH, soc_pkg::UART_IO_MASK))
      slave_sel[soc_pkg::SEL_UART] = 1'b1;
    else if (hit(tag_adr, soc_pkg::GPIO_IO_MATCH, soc_pkg::GPIO_IO_MASK))
      slave_sel[soc_pkg::SEL_GPIO] = 1'b1;
    else if (hit(tag_adr, soc_pkg::MEM_ANY_MATCH, soc_pkg::MEM_ANY_MASK))
      slave_sel[soc_pkg::SEL_MEM] = 1'b1;
    else
      slave_sel[soc_pkg::SEL_DEF] = 1'b1;
  end

  // Everything but cycle/strobe is common to all slaves
  assign slv_adr_o = m_adr_i;
  assign slv_tga_o = m_tga_i;
  assign slv_dat_o = m_dat_i;
  assign slv_sel_o = m_sel_i;
  assign slv_we_o  = m_we_i;

  assign rom_cyc_o  = m_cyc_i & slave_sel[soc_pkg::SEL_ROM];
  assign rom_stb_o  = m_stb_i & slave_sel[soc_pkg::SEL_ROM];
  assign vga_cyc_o  = m_cyc_i & slave_sel[soc_pkg::SEL_VGA];
  assign vga_stb_o  = m_stb_i & slave_sel[soc_pkg::SEL_VGA];
  assign uart_cyc_o = m_cyc_i & slave_sel[soc_pkg::SEL_UART];
  assign uart_stb_o = m_stb_i & slave_sel[soc_pkg::SEL_UART];
  assign gpio_cyc_o = m_cyc_i & slave_sel[soc_pkg::SEL_GPIO];
  assign gpio_stb_o = m_stb_i & slave_sel[soc_pkg::SEL_GPIO];
  assign mem_cyc_o  = m_cyc_i & slave_sel[soc_pkg::SEL_MEM];
  assign mem_stb_o  = m_stb_i & slave_sel[soc_pkg::SEL_MEM];

  // Return path; unmapped requests are answered here at once
  always_comb
  begin
    case (1'b1)
      slave_sel[soc_pkg::SEL_ROM]:
      begin
        ret_dat = rom_dat_i;
        ret_ack = rom_ack_i;
      end
      slave_sel[soc_pkg::SEL_VGA]:
      begin
        ret_dat = vga_dat_i;
        ret_ack = vga_ack_i;
      end
      slave_sel[soc_pkg::SEL_UART]:
      begin
        ret_dat = uart_dat_i;
        ret_ack = uart_ack_i;
      end
      slave_sel[soc_pkg::SEL_GPIO]:
      begin
        ret_dat = gpio_dat_i;
        ret_ack = gpio_ack_i;
      end
      slave_sel[soc_pkg::SEL_MEM]:
      begin
        ret_dat = mem_dat_i;
        ret_ack = mem_ack_i;
      end
      default:
      begin
        ret_dat = soc_pkg::DEFAULT_DATA;
        ret_ack = m_cyc_i & m_stb_i;
      end
    endcase
  end

  // During interrupt acknowledge the CPU reads the vector instead
  assign m_dat_o = inta_i ? soc_pkg::INTA_BASE + soc_pkg::bus_data_t'(iid_i) : ret_dat;
  assign m_ack_o = ret_ack;

  // A slave may only acknowledge a request that is still present
  ack_req_a: assert final (!m_ack_o || (m_cyc_i && m_stb_i))
    else $error("bus_switch: acknowledge without a pending request");

endmodule

/* verilog/reset_debouncer.sv */
// Reset debouncer: holds system reset while the PLL is unlocked or the button pressed, then longer
`timescale 1ns/100ps

module reset_debouncer (
  input  logic clk,
  input  logic rst,
  input  logic pll_lock_i,
  input  logic rst_button_i,
  output logic sys_rst_o
);

  logic [soc_pkg::RST_HOLD_BITS-1:0] hold_cnt;

  // Reload on any reset request, count down once it is gone
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      hold_cnt  <= '1;
      sys_rst_o <= 1'b1;
    end
    else
    begin
      if (!pll_lock_i || rst_button_i)
        hold_cnt <= '1;
      else if (hold_cnt != '0)
        hold_cnt <= hold_cnt - 1'b1;
      sys_rst_o <= hold_cnt != '0;
    end
  end

  // Loss of lock reaches the system reset two edges later
  unlock_hold_a: assert property (@(posedge clk) disable iff (rst)
    !pll_lock_i |-> ##2 sys_rst_o)
    else $error("reset_debouncer: system reset low after PLL unlock");

endmodule

/* verilog/timer_clock_divider.sv */
// Timer clock divider: makes the system timer clock by dividing the bus clock by 21
`timescale 1ns/100ps

module timer_clock_divider (
  input  logic clk,
  input  logic rst,
  output logic timer_clk_o
);

  logic [4:0] div_cnt;

  // High for 10 cycles, low for 11
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      div_cnt     <= '0;
      timer_clk_o <= 1'b0;
    end
    else if (div_cnt == soc_pkg::TIMER_DIV_LAST)
    begin
      div_cnt     <= '0;
      timer_clk_o <= 1'b0;
    end
    else
    begin
      if (div_cnt == soc_pkg::TIMER_DIV_HIGH)
        timer_clk_o <= 1'b1;
      div_cnt <= div_cnt + 1'b1;
    end
  end

  cnt_range_a: assert property (@(posedge clk) disable iff (rst)
    div_cnt <= soc_pkg::TIMER_DIV_LAST)
    else $error("timer_clock_divider: counter past wrap value %0d", div_cnt);

endmodule

/* verilog/gpio_leds.sv */
// Switch and LED register: bus slave that reads the board switches and drives the LEDs
`timescale 1ns/100ps

module gpio_leds (
  input  logic               clk,
  input  logic               rst,
  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  soc_pkg::bus_sel_t  sel_i,
  input  soc_pkg::bus_data_t dat_i,
  input  soc_pkg::sw_t       sw_i,
  output soc_pkg::bus_data_t dat_o,
  output logic               ack_o,
  output soc_pkg::led_t      leds_o
);

  logic req;

  // New request only while no acknowledge is pending
  assign req = cyc_i & stb_i & ~ack_o;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ack_o  <= 1'b0;
      leds_o <= '0;
    end
    else
    begin
      ack_o <= req;
      if (req && we_i)
      begin
        if (sel_i[0])
          leds_o[7:0] <= dat_i[7:0];
        if (sel_i[1])
          leds_o[13:8] <= dat_i[13:8];
      end
    end
  end

  // Switch snapshot taken with the acknowledge
  always_ff @(posedge clk)
  begin
    if (req)
      dat_o <= soc_pkg::bus_data_t'(sw_i);
  end

endmodule

/* verilog/soc_glue_top.sv */
// SoC glue top level: ties bus switch, reset debouncer, timer divider and GPIO together
`timescale 1ns/100ps

module soc_glue_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               pll_lock_i,
  input  logic               rst_button_i,
  input  soc_pkg::sw_t       sw_i,

  // CPU master port
  input  soc_pkg::bus_addr_t m_adr_i,
  input  logic               m_tga_i,
  input  soc_pkg::bus_data_t m_dat_i,
  input  soc_pkg::bus_sel_t  m_sel_i,
  input  logic               m_we_i,
  input  logic               m_cyc_i,
  input  logic               m_stb_i,
  input  logic               inta_i,
  input  soc_pkg::iid_t      iid_i,
  output soc_pkg::bus_data_t m_dat_o,
  output logic               m_ack_o,

  // Shared slave signals
  output soc_pkg::bus_addr_t slv_adr_o,
  output logic               slv_tga_o,
  output soc_pkg::bus_data_t slv_dat_o,
  output soc_pkg::bus_sel_t  slv_sel_o,
  output logic               slv_we_o,

  // External slaves
  output logic               rom_cyc_o,
  output logic               rom_stb_o,
  input  soc_pkg::bus_data_t rom_dat_i,
  input  logic               rom_ack_i,
  output logic               vga_cyc_o,
  output logic               vga_stb_o,
  input  soc_pkg::bus_data_t vga_dat_i,
  input  logic               vga_ack_i,
  output logic               uart_cyc_o,
  output logic               uart_stb_o,
  input  soc_pkg::bus_data_t uart_dat_i,
  input  logic               uart_ack_i,
  output logic               mem_cyc_o,
  output logic               mem_stb_o,
  input  soc_pkg::bus_data_t mem_dat_i,
  input  logic               mem_ack_i,

  output soc_pkg::led_t      leds_o,
  output logic               sys_rst_o,
  output logic               timer_clk_o
);

  // Internal GPIO slave
  logic               gpio_cyc;
  logic               gpio_stb;
  soc_pkg::bus_data_t gpio_dat;
  logic               gpio_ack;

  bus_switch u_bus_switch (
    .m_adr_i    (m_adr_i),
    .m_tga_i    (m_tga_i),
    .m_dat_i    (m_dat_i),
    .m_sel_i    (m_sel_i),
    .m_we_i     (m_we_i),
    .m_cyc_i    (m_cyc_i),
    .m_stb_i    (m_stb_i),
    .inta_i     (inta_i),
    .iid_i      (iid_i),
    .m_dat_o    (m_dat_o),
    .m_ack_o    (m_ack_o),
    .slv_adr_o  (slv_adr_o),
    .slv_tga_o  (slv_tga_o),
    .slv_dat_o  (slv_dat_o),
    .slv_sel_o  (slv_sel_o),
    .slv_we_o   (slv_we_o),
    .rom_cyc_o  (rom_cyc_o),
    .rom_stb_o  (rom_stb_o),
    .rom_dat_i  (rom_dat_i),
    .rom_ack_i  (rom_ack_i),
    .vga_cyc_o  (vga_cyc_o),
    .vga_stb_o  (vga_stb_o),
    .vga_dat_i  (vga_dat_i),
    .vga_ack_i  (vga_ack_i),
    .uart_cyc_o (uart_cyc_o),
    .uart_stb_o (uart_stb_o),
    .uart_dat_i (uart_dat_i),
    .uart_ack_i (uart_ack_i),
    .mem_cyc_o  (mem_cyc_o),
    .mem_stb_o  (mem_stb_o),
    .mem_dat_i  (mem_dat_i),
    .mem_ack_i  (mem_ack_i),
    .gpio_cyc_o (gpio_cyc),
    .gpio_stb_o (gpio_stb),
    .gpio_dat_i (gpio_dat),
    .gpio_ack_i (gpio_ack)
  );

  reset_debouncer u_reset_debouncer (
    .clk          (clk),
    .rst          (rst),
    .pll_lock_i   (pll_lock_i),
    .rst_button_i (rst_button_i),
    .sys_rst_o    (sys_rst_o)
  );

  timer_clock_divider u_timer_clock_divider (
    .clk         (clk),
    .rst         (rst),
    .timer_clk_o (timer_clk_o)
  );

  // Write data, select and strobe come from the shared slave bus
  gpio_leds u_gpio_leds (
    .clk    (clk),
    .rst    (rst),
    .cyc_i  (gpio_cyc),
    .stb_i  (gpio_stb),
    .we_i   (slv_we_o),
    .sel_i  (slv_sel_o),
    .dat_i  (slv_dat_o),
    .sw_i   (sw_i),
    .dat_o  (gpio_dat),
    .ack_o  (gpio_ack),
    .leds_o (leds_o)
  );

endmodule

/* testbench/tb_soc_glue.sv */
// Testbench for the SoC glue top level; directed tests with external slave models and a timeout
`timescale 1ns/100ps

module tb_soc_glue;

  // Debounce wait of 1024 plus about 250 cycles of tests
  localparam int CYCLE_LIMIT = 1400;
  localparam int ACK_LIMIT   = 16;

  logic               clk = 1'b0;
  logic               rst;
  logic               pll_lock_i;
  logic               rst_button_i;
  soc_pkg::sw_t       sw_i;
  soc_pkg::bus_addr_t m_adr_i;
  logic               m_tga_i;
  soc_pkg::bus_data_t m_dat_i;
  soc_pkg::bus_sel_t  m_sel_i;
  logic               m_we_i;
  logic               m_cyc_i;
  logic               m_stb_i;
  logic               inta_i;
  soc_pkg::iid_t      iid_i;
  soc_pkg::bus_data_t m_dat_o;
  logic               m_ack_o;
  soc_pkg::bus_addr_t slv_adr_o;
  logic               slv_tga_o;
  soc_pkg::bus_data_t slv_dat_o;
  soc_pkg::bus_sel_t  slv_sel_o;
  logic               slv_we_o;
  logic               rom_cyc_o, rom_stb_o, vga_cyc_o, vga_stb_o;
  logic               uart_cyc_o, uart_stb_o, mem_cyc_o, mem_stb_o;
  logic               rom_ack_i = 1'b0;
  logic               vga_ack_i = 1'b0;
  logic               uart_ack_i = 1'b0;
  logic               mem_ack_i = 1'b0;
  soc_pkg::bus_data_t rom_dat_i, vga_dat_i, uart_dat_i, mem_dat_i;
  soc_pkg::led_t      leds_o;
  logic               sys_rst_o;
  logic               timer_clk_o;

  int err_cnt = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int cycle_cnt = 0;

  soc_glue_top UUT (.*);

  always #50 clk = ~clk;

  // External slaves: ack one cycle after strobe, data is a tag word plus low address bits
  always @(posedge clk)
  begin
    rom_ack_i  <= rom_cyc_o & rom_stb_o & ~rom_ack_i;
    vga_ack_i  <= vga_cyc_o & vga_stb_o & ~vga_ack_i;
    uart_ack_i <= uart_cyc_o & uart_stb_o & ~uart_ack_i;
    mem_ack_i  <= mem_cyc_o & mem_stb_o & ~mem_ack_i;
  end

  assign rom_dat_i  = 16'ha000 + {4'h0, slv_adr_o[11:0]};
  assign vga_dat_i  = 16'hb000 + {4'h0, slv_adr_o[11:0]};
  assign uart_dat_i = 16'hc000 + {4'h0, slv_adr_o[11:0]};
  assign mem_dat_i  = 16'hd000 + {4'h0, slv_adr_o[11:0]};

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("Run stopped: cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  task automatic report_error(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("Error in %s: expected %0h, actual %0h", test, expected, actual);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int start_errs);
    tests_run++;
    if (err_cnt != start_errs)
      tests_bad++;
    $display("%s finished with %0d errors", name, err_cnt - start_errs);
  endtask

  // One master read or write, returning {cyc, stb} of rom, vga, uart, mem from the first
  // request cycle
  task automatic bus_access(input logic io, input logic [19:0] byte_adr, input logic we,
                            input soc_pkg::bus_sel_t sel, input soc_pkg::bus_data_t wdat,
                            output soc_pkg::bus_data_t rdat, output logic [7:0] stb,
                            output int cycles, output logic ok);
    rdat = '0;
    stb = '0;
    cycles = 0;
    ok = 1'b0;
    @(posedge clk);
    m_adr_i <= byte_adr[19:1];
    m_tga_i <= io;
    m_we_i  <= we;
    m_sel_i <= sel;
    m_dat_i <= wdat;
    m_cyc_i <= 1'b1;
    m_stb_i <= 1'b1;
    while (!ok && cycles < ACK_LIMIT)
    begin
      @(negedge clk);
      cycles++;
      if (cycles == 1)
      begin
        stb = {rom_cyc_o, vga_cyc_o, uart_cyc_o, mem_cyc_o,
               rom_stb_o, vga_stb_o, uart_stb_o, mem_stb_o};
        // Shared slave signals pass the master request straight through
        if ({slv_tga_o, slv_adr_o} !== {io, byte_adr[19:1]})
          report_error("bus_access shared address", {io, byte_adr[19:1]},
                       {slv_tga_o, slv_adr_o});
        if ({slv_we_o, slv_sel_o, slv_dat_o} !== {we, sel, wdat})
          report_error("bus_access shared write fields", {we, sel, wdat},
                       {slv_we_o, slv_sel_o, slv_dat_o});
      end
      if (m_ack_o)
      begin
        ok = 1'b1;
        rdat = m_dat_o;
      end
    end
    @(posedge clk);
    m_cyc_i <= 1'b0;
    m_stb_i <= 1'b0;
    m_we_i  <= 1'b0;
    if (!ok)
    begin
      $display("Access to address %h got no acknowledge within %0d cycles", byte_adr, ACK_LIMIT);
      err_cnt++;
    end
  endtask

  task automatic measure_run(input logic level, output int len);
    len = 0;
    while (timer_clk_o === level && len < 40)
    begin
      len++;
      @(negedge clk);
    end
  endtask

  // Starts in the cycle of reset release, first rise on the 11th edge
  task automatic timer_clock_test();
    int start;
    int len;
    int p;
    start = err_cnt;
    @(negedge clk);
    measure_run(1'b0, len);
    if (len != 11)
      report_error("timer_clock first low run", 11, len);
    for (p = 0; p < 3; p++)
    begin
      measure_run(1'b1, len);
      if (len != 10)
        report_error("timer_clock high run", 10, len);
      measure_run(1'b0, len);
      if (len != 11)
        report_error("timer_clock low run", 11, len);
    end
    finish_test("timer_clock", start);
  endtask

  task automatic reset_hold_test();
    int start;
    int n;
    start = err_cnt;
    repeat (8)
    begin
      @(negedge clk);
      if (sys_rst_o !== 1'b1)
        report_error("reset_hold while unlocked", 1, sys_rst_o);
    end
    @(posedge clk);
    pll_lock_i <= 1'b1;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      @(negedge clk);
    end while (sys_rst_o && n < 1100);
    if (n != 1024)
      report_error("reset_hold release edge", 1024, n);
    @(posedge clk);
    rst_button_i <= 1'b1;
    n = 0;
    do
    begin
      @(posedge clk);
      n++;
      @(negedge clk);
    end while (!sys_rst_o && n < 4);
    if (n != 2)
      report_error("reset_hold button edge", 2, n);
    @(posedge clk);
    rst_button_i <= 1'b0;
    finish_test("reset_hold", start);
  endtask

  task automatic check_window(input string win, input logic io, input logic [19:0] base,
                              input logic [19:0] size, input soc_pkg::bus_data_t tag,
                              input logic [3:0] exp_stb);
    logic [19:0]        adr;
    soc_pkg::bus_data_t rdat;
    soc_pkg::bus_data_t exp_dat;
    logic [7:0]         stb;
    int                 cycles;
    logic               ok;
    int                 i;
    for (i = 0; i < 3; i++)
    begin
      adr = base + 20'($urandom % size);
      adr[0] = 1'b0;
      bus_access(io, adr, 1'b0, 2'b11, 16'h0000, rdat, stb, cycles, ok);
      if (stb !== {exp_stb, exp_stb})
        report_error({"address_decode strobes ", win}, {exp_stb, exp_stb}, stb);
      exp_dat = tag + {4'h0, adr[12:1]};
      if (ok && rdat !== exp_dat)
        report_error({"address_decode data ", win}, exp_dat, rdat);
    end
  endtask

  task automatic address_decode_test();
    int start;
    start = err_cnt;
    check_window("rom_mem1", 1'b0, 20'hf0000, 20'h10000, 16'ha000, 4'b1000);
    check_window("rom_mem2", 1'b0, 20'hc0000, 20'h10000, 16'ha000, 4'b1000);
    check_window("rom_io", 1'b1, 20'h0e000, 20'h00200, 16'ha000, 4'b1000);
    check_window("vga_mem", 1'b0, 20'ha0000, 20'h20000, 16'hb000, 4'b0100);
    check_window("vga_io", 1'b1, 20'h003c0, 20'h00020, 16'hb000, 4'b0100);
    check_window("uart_io", 1'b1, 20'h003f8, 20'h00008, 16'hc000, 4'b0010);
    check_window("low_mem", 1'b0, 20'h00000, 20'ha0000, 16'hd000, 4'b0001);
    finish_test("address_decode", start);
  endtask

  task automatic gpio_test();
    int                 start;
    soc_pkg::bus_data_t rdat;
    logic [7:0]         stb;
    int                 cycles;
    logic               ok;
    start = err_cnt;
    if (leds_o !== 14'h0000)
      report_error("gpio leds after reset", 0, leds_o);
    bus_access(1'b1, 20'h0f100, 1'b1, 2'b11, 16'h3a5c, rdat, stb, cycles, ok);
    @(negedge clk);
    if (leds_o !== 14'h3a5c)
      report_error("gpio write both lanes", 14'h3a5c, leds_o);
    // Upper lane keeps its value
    bus_access(1'b1, 20'h0f100, 1'b1, 2'b01, 16'h1f77, rdat, stb, cycles, ok);
    @(negedge clk);
    if (leds_o !== 14'h3a77)
      report_error("gpio write low lane", 14'h3a77, leds_o);
    @(posedge clk);
    sw_i <= 10'h2b6;
    bus_access(1'b1, 20'h0f100, 1'b0, 2'b11, 16'h0000, rdat, stb, cycles, ok);
    if (ok && rdat !== 16'h02b6)
      report_error("gpio read switches", 16'h02b6, rdat);
    if (stb !== 8'h00)
      report_error("gpio external strobes", 0, stb);
    finish_test("gpio", start);
  endtask

  task automatic default_slave_test();
    int                 start;
    soc_pkg::bus_data_t rdat;
    logic [7:0]         stb;
    int                 cycles;
    logic               ok;
    start = err_cnt;
    bus_access(1'b1, 20'h00060, 1'b0, 2'b11, 16'h0000, rdat, stb, cycles, ok);
    if (ok && cycles != 1)
      report_error("default_slave ack cycle at 0x60", 1, cycles);
    if (ok && rdat !== 16'hffff)
      report_error("default_slave data at 0x60", 16'hffff, rdat);
    if (stb !== 8'h00)
      report_error("default_slave strobes at 0x60", 0, stb);
    bus_access(1'b1, 20'h00040, 1'b0, 2'b11, 16'h0000, rdat, stb, cycles, ok);
    if (ok && cycles != 1)
      report_error("default_slave ack cycle at 0x40", 1, cycles);
    if (ok && rdat !== 16'hffff)
      report_error("default_slave data at 0x40", 16'hffff, rdat);
    if (stb !== 8'h00)
      report_error("default_slave strobes at 0x40", 0, stb);
    finish_test("default_slave", start);
  endtask

  // Address points at the boot ROM, the vector must win anyway
  task automatic inta_vector_test();
    int                 start;
    int                 id;
    soc_pkg::bus_data_t exp_dat;
    start = err_cnt;
    for (id = 0; id < 8; id++)
    begin
      @(posedge clk);
      m_tga_i <= 1'b0;
      m_adr_i <= 19'h78000;
      inta_i  <= 1'b1;
      iid_i   <= id[2:0];
      @(negedge clk);
      exp_dat = 16'h0008 + id[15:0];
      if (m_dat_o !== exp_dat)
        report_error("inta_vector", exp_dat, m_dat_o);
    end
    @(posedge clk);
    inta_i <= 1'b0;
    finish_test("inta_vector", start);
  endtask

  initial
  begin
    void'($urandom(32'h07a7_7ec3));
    rst = 1'b1;
    pll_lock_i = 1'b0;
    rst_button_i = 1'b0;
    sw_i = '0;
    m_adr_i = '0;
    m_tga_i = 1'b0;
    m_dat_i = '0;
    m_sel_i = '0;
    m_we_i = 1'b0;
    m_cyc_i = 1'b0;
    m_stb_i = 1'b0;
    inta_i = 1'b0;
    iid_i = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // PLL stays unlocked through the timer test
    timer_clock_test();
    reset_hold_test();
    address_decode_test();
    gpio_test();
    default_slave_test();
    inta_vector_test();
    $display("Tests run: %0d, tests with errors: %0d, failed checks: %0d",
             tests_run, tests_bad, err_cnt);
    if (err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* list.f */
verilog/soc_pkg.sv
verilog/bus_switch.sv
verilog/reset_debouncer.sv
verilog/timer_clock_divider.sv
verilog/gpio_leds.sv
verilog/soc_glue_top.sv
testbench/tb_soc_glue.sv

/* Bender.yml */
package:
  name: soc_glue

sources:
  - verilog/soc_pkg.sv
  - verilog/bus_switch.sv
  - verilog/reset_debouncer.sv
  - verilog/timer_clock_divider.sv
  - verilog/gpio_leds.sv
  - verilog/soc_glue_top.sv
  - target: simulation
    files:
      - testbench/tb_soc_glue.sv
